/* hw/cpu_pkg.sv */
package cpu_pkg;

localparam int PHY_REGS = 46;

typedef logic [5:0]  phy_reg_t;
typedef logic [3:0]  arch_reg_t;
typedef logic [3:0]  cr_idx_t;
typedef logic [31:0] word_t;
typedef logic [4:0]  mode_t;

localparam mode_t MODE_USR = 5'b10000;
localparam mode_t MODE_FIQ = 5'b10001;
localparam mode_t MODE_IRQ = 5'b10010;
localparam mode_t MODE_SVC = 5'b10011;
localparam mode_t MODE_ABT = 5'b10111;
localparam mode_t MODE_UND = 5'b11011;
localparam mode_t MODE_SYS = 5'b11111;

localparam int CPSR_T = 5;

// Start of each banked group in the physical file.
localparam phy_reg_t PHY_FIQ_R8  = 6'd16;
localparam phy_reg_t PHY_IRQ_R13 = 6'd23;
localparam phy_reg_t PHY_SVC_R13 = 6'd25;
localparam phy_reg_t PHY_ABT_R13 = 6'd27;
localparam phy_reg_t PHY_UND_R13 = 6'd29;

// LDC/STC at 27:25, MCR/MRC/CDP at 27:24.
function automatic logic is_coproc(input word_t instr);
        return (instr[27:25] == 3'b110) || (instr[27:24] == 4'b1110);
endfunction

function automatic logic is_reg_transfer(input word_t instr);
        return (instr[27:24] == 4'b1110) && instr[4]; // CDP has bit 4 clear.
endfunction

function automatic logic is_mrc(input word_t instr);
        return is_reg_transfer(instr) && instr[20];
endfunction

typedef struct packed {
        logic   valid;
        word_t  instr;
        logic   irq;
        logic   fiq;
} fetch_bus_t;

typedef struct packed {
        logic     dav;
        word_t    word;
        phy_reg_t preg;
} copro_req_t;

typedef struct packed {
        logic     en;
        phy_reg_t addr;
        word_t    data;
} rf_wr_t;

typedef enum logic {IDLE, BUSY} cp_state_t;

typedef enum logic [1:0] {CU_IDLE, CU_READ, CU_DONE} cu_state_t;

endpackage

/* hw/reg_translate.sv */
`timescale 1ns/1ps

module reg_translate
(
        input  cpu_pkg::arch_reg_t      i_arch,
        input  cpu_pkg::mode_t          i_mode,
        output cpu_pkg::phy_reg_t       o_phy
);

import cpu_pkg::*;

logic fiq_banked;
logic sp_lr;

// SP and LR pair, R14 one above R13.
function automatic phy_reg_t bank_pair(input phy_reg_t base, input arch_reg_t r);
        phy_reg_t ofs;
        ofs = (r == 4'd14) ? 6'd1 : 6'd0;
        return base + ofs;
endfunction

assign fiq_banked = i_arch[3] && (i_arch != 4'd15);     // R8 to R14.
assign sp_lr      = (i_arch == 4'd13) || (i_arch == 4'd14);

always_comb
begin
        o_phy = {2'b00, i_arch};

        case (i_mode)
        MODE_FIQ:
        begin
                if (fiq_banked)
                        o_phy = PHY_FIQ_R8 + {3'b000, i_arch[2:0]};
        end
        MODE_IRQ:
        begin
                if (sp_lr)
                        o_phy = bank_pair(PHY_IRQ_R13, i_arch);
        end
        MODE_SVC:
        begin
                if (sp_lr)
                        o_phy = bank_pair(PHY_SVC_R13, i_arch);
        end
        MODE_ABT:
        begin
                if (sp_lr)
                        o_phy = bank_pair(PHY_ABT_R13, i_arch);
        end
        MODE_UND:
        begin
                if (sp_lr)
                        o_phy = bank_pair(PHY_UND_R13, i_arch);
        end
        default:
        begin
                o_phy = {2'b00, i_arch}; // USR, SYS and anything odd.
        end
        endcase
end

endmodule

/* hw/predecode_coproc.sv */
`timescale 1ns/1ps

module predecode_coproc
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  cpu_pkg::fetch_bus_t     i_fetch,
        input  cpu_pkg::word_t          i_cpsr,

        input  logic                    i_clear_from_writeback, // Highest priority.
        input  logic                    i_clear_from_alu,
        input  logic                    i_stall_from_shifter,
        input  logic                    i_stall_from_issue,     // Lowest priority.

        input  logic                    i_pipeline_dav,
        input  logic                    i_copro_done,

        output cpu_pkg::fetch_bus_t     o_decode,
        output logic                    o_stall_from_decode,
        output cpu_pkg::copro_req_t     o_copro_req
);

import cpu_pkg::*;

cp_state_t      state_ff;
cp_state_t      state_nxt;
copro_req_t     req_nxt;
logic           cp_hit;
logic           hold;
arch_reg_t      cp_arch;
phy_reg_t       cp_phy;

// Only in ARM state.
assign cp_hit = i_fetch.valid && !i_cpsr[CPSR_T] && is_coproc(i_fetch.instr);

assign hold = i_clear_from_writeback || i_clear_from_alu ||
              i_stall_from_shifter || i_stall_from_issue;

// Rd for register transfers, Rn for the rest.
assign cp_arch = is_reg_transfer(i_fetch.instr) ? i_fetch.instr[15:12]
                                                : i_fetch.instr[19:16];

reg_translate u_translate
(
        .i_arch (cp_arch),
        .i_mode (i_cpsr[4:0]),
        .o_phy  (cp_phy)
);

always_comb
begin
        state_nxt           = state_ff;
        req_nxt             = o_copro_req;
        o_decode            = '0;
        o_stall_from_decode = 1'b0;

        case (state_ff)
        IDLE:
        begin
                req_nxt = '0;

                if (cp_hit)
                begin
                        o_stall_from_decode = 1'b1;

                        // Wait for the pipeline to drain.
                        if (!i_pipeline_dav)
                        begin
                                req_nxt.dav  = 1'b1;
                                req_nxt.word = i_fetch.instr;
                                req_nxt.preg = cp_phy;
                                state_nxt    = BUSY;
                        end
                end
                else
                begin
                        o_decode = i_fetch; // Transparent.
                end
        end

        BUSY:
        begin
                o_stall_from_decode = 1'b1;

                if (i_copro_done)
                begin
                        req_nxt   = '0;
                        state_nxt = IDLE;

                        if (!hold)
                                o_stall_from_decode = 1'b0;
                end
        end

        default:
        begin
                state_nxt = IDLE;
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff    <= IDLE;
                o_copro_req <= '0;
        end
        else if (i_clear_from_writeback || i_clear_from_alu)
        begin
                state_ff    <= IDLE;
                o_copro_req <= '0;
        end
        else if (i_stall_from_shifter || i_stall_from_issue)
        begin
                state_ff    <= state_ff;        // Frozen.
                o_copro_req <= o_copro_req;
        end
        else
        begin
                state_ff    <= state_nxt;
                o_copro_req <= req_nxt;
        end
end

endmodule

/* hw/pipe_occupancy.sv */
`timescale 1ns/1ps

module pipe_occupancy #(
        parameter int PIPE_DEPTH = 8
)
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_clear_from_writeback,
        input  logic    i_clear_from_alu,
        input  logic    i_issue,
        input  logic    i_retire,
        output logic    o_pipeline_dav
);

localparam int CW = $clog2(PIPE_DEPTH + 1);

localparam logic [CW-1:0] FULL = CW'(PIPE_DEPTH);

logic [CW-1:0] count_ff;
logic          up;
logic          down;

// Issue and retire together leave the count alone.
assign up   = i_issue && !i_retire && (count_ff != FULL);
assign down = i_retire && !i_issue && (count_ff != '0);

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear_from_writeback || i_clear_from_alu)
                count_ff <= '0;
        else if (up)
                count_ff <= count_ff + 1'b1;
        else if (down)
                count_ff <= count_ff - 1'b1;
end

assign o_pipeline_dav = (count_ff != '0);

endmodule

/* hw/coproc_unit.sv */
`timescale 1ns/1ps

module coproc_unit
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  cpu_pkg::copro_req_t     i_req,
        output logic                    o_done,

        output cpu_pkg::phy_reg_t       o_rf_rd_addr,
        input  cpu_pkg::word_t          i_rf_rd_data,
        output cpu_pkg::rf_wr_t         o_rf_wr
);

import cpu_pkg::*;

cu_state_t      state_ff;
word_t          cr_ff [16];
cr_idx_t        crn;
logic           wr_en_ff;
phy_reg_t       wr_addr_ff;
word_t          wr_data_ff;
logic           do_mcr;
logic           do_mrc;

assign crn = i_req.word[19:16];

// Commit happens on the CU_READ to CU_DONE edge.
assign do_mcr = (state_ff == CU_READ) && i_req.dav &&
                is_reg_transfer(i_req.word) && !i_req.word[20];
assign do_mrc = (state_ff == CU_READ) && i_req.dav && is_mrc(i_req.word);

assign o_rf_rd_addr = i_req.preg;
assign o_done       = (state_ff == CU_DONE);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= CU_IDLE;
                wr_en_ff <= 1'b0;
        end
        else
        begin
                wr_en_ff <= do_mrc; // One pulse only.

                case (state_ff)
                CU_IDLE:
                begin
                        if (i_req.dav)
                                state_ff <= CU_READ;
                end
                CU_READ:
                begin
                        if (i_req.dav)
                                state_ff <= CU_DONE;
                        else
                                state_ff <= CU_IDLE;    // Request withdrawn by a clear.
                end
                CU_DONE:
                begin
                        if (!i_req.dav)
                                state_ff <= CU_IDLE;
                end
                default:
                begin
                        state_ff <= CU_IDLE;
                end
                endcase
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < 16; i++)
                        cr_ff[i] <= '0;
        end
        else if (do_mcr)
        begin
                cr_ff[crn] <= i_rf_rd_data;
        end
end

always_ff @(posedge i_clk)
begin
        if (do_mrc)
        begin
                wr_addr_ff <= i_req.preg;
                wr_data_ff <= cr_ff[crn];
        end
end

assign o_rf_wr = '{en: wr_en_ff, addr: wr_addr_ff, data: wr_data_ff};

endmodule

/* hw/phy_regfile.sv */
`timescale 1ns/1ps

module phy_regfile
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  cpu_pkg::rf_wr_t         i_wb,
        input  cpu_pkg::rf_wr_t         i_cp_wr,

        input  cpu_pkg::phy_reg_t       i_rd_addr_a,
        output cpu_pkg::word_t          o_rd_data_a,
        input  cpu_pkg::phy_reg_t       i_rd_addr_b,
        output cpu_pkg::word_t          o_rd_data_b
);

import cpu_pkg::*;

word_t regs_ff [PHY_REGS];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < PHY_REGS; i++)
                        regs_ff[i] <= '0;
        end
        else
        begin
                if (i_wb.en && (i_wb.addr < PHY_REGS))
                        regs_ff[i_wb.addr] <= i_wb.data;

                // Later assignment, so coprocessor wins a collision.
                if (i_cp_wr.en && (i_cp_wr.addr < PHY_REGS))
                        regs_ff[i_cp_wr.addr] <= i_cp_wr.data;
        end
end

// Spare addresses above the map read as zero.
assign o_rd_data_a = (i_rd_addr_a < PHY_REGS) ? regs_ff[i_rd_addr_a] : '0;
assign o_rd_data_b = (i_rd_addr_b < PHY_REGS) ? regs_ff[i_rd_addr_b] : '0;

endmodule

/* hw/coproc_top.sv */
`timescale 1ns/1ps

module coproc_top #(
        parameter int PIPE_DEPTH = 8
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cpu_pkg::fetch_bus_t     i_fetch,
        input  cpu_pkg::word_t          i_cpsr,
        input  logic                    i_clear_from_writeback,
        input  logic                    i_clear_from_alu,
        input  logic                    i_stall_from_shifter,
        input  logic                    i_stall_from_issue,
        input  logic                    i_retire,
        input  cpu_pkg::rf_wr_t         i_wb,
        input  cpu_pkg::phy_reg_t       i_rd_addr,
        output cpu_pkg::fetch_bus_t     o_decode,
        output logic                    o_stall_from_decode,
        output cpu_pkg::word_t          o_rd_data,
        output cpu_pkg::copro_req_t     o_copro_req
);

import cpu_pkg::*;

logic           copro_done;
logic           pipeline_dav;
phy_reg_t       cp_rd_addr;
word_t          cp_rd_data;
rf_wr_t         cp_wr;

predecode_coproc u_predecode
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_fetch                (i_fetch),
        .i_cpsr                 (i_cpsr),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_pipeline_dav         (pipeline_dav),
        .i_copro_done           (copro_done),
        .o_decode               (o_decode),
        .o_stall_from_decode    (o_stall_from_decode),
        .o_copro_req            (o_copro_req)
);

pipe_occupancy #(.PIPE_DEPTH(PIPE_DEPTH)) u_occupancy
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_issue                (o_decode.valid && !i_stall_from_shifter && !i_stall_from_issue),
        .i_retire               (i_retire),
        .o_pipeline_dav         (pipeline_dav)
);

coproc_unit u_coproc
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_req                  (o_copro_req),
        .o_done                 (copro_done),
        .o_rf_rd_addr           (cp_rd_addr),
        .i_rf_rd_data           (cp_rd_data),
        .o_rf_wr                (cp_wr)
);

phy_regfile u_regfile
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_wb                   (i_wb),
        .i_cp_wr                (cp_wr),
        .i_rd_addr_a            (i_rd_addr),
        .o_rd_data_a            (o_rd_data),
        .i_rd_addr_b            (cp_rd_addr),
        .o_rd_data_b            (cp_rd_data)
);

endmodule

/* tb/tb_coproc_top.sv */
`timescale 1ns/1ps

module tb_coproc_top;

import cpu_pkg::*;

localparam int PIPE_DEPTH = 8;
localparam int WAIT_LIMIT = 32;
localparam int TIMEOUT_CYCLES = 3000;   // Tests need about 600.
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic           i_clk;
logic           i_reset;
fetch_bus_t     i_fetch;
word_t          i_cpsr;
logic           i_clear_from_writeback;
logic           i_clear_from_alu;
logic           i_stall_from_shifter;
logic           i_stall_from_issue;
logic           i_retire;
rf_wr_t         i_wb;
phy_reg_t       i_rd_addr;
fetch_bus_t     o_decode;
logic           o_stall_from_decode;
word_t          o_rd_data;
copro_req_t     o_copro_req;

logic [31:0]    lfsr_state = 32'd29;
int             error_count = 0;
int             check_count = 0;
int             cycle_count = 0;
word_t          cr5_value;

coproc_top #(.PIPE_DEPTH(PIPE_DEPTH)) i_dut
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_fetch                (i_fetch),
        .i_cpsr                 (i_cpsr),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_retire               (i_retire),
        .i_wb                   (i_wb),
        .i_rd_addr              (i_rd_addr),
        .o_decode               (o_decode),
        .o_stall_from_decode    (o_stall_from_decode),
        .o_rd_data              (o_rd_data),
        .o_copro_req            (o_copro_req)
);

initial
begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
end

always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
                $display("Timeout after %0d cycles, run stopped", cycle_count);
                $display("Test failures found");
                $finish;
        end
end

// Galois LFSR, one step per bit.
function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
                lfsr_state = lfsr_state ^ LFSR_TAPS;
        return out;
endfunction

function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++)
                w = {w[30:0], lfsr_bit()};
        return w;
endfunction

// Banking map of the core.
function automatic phy_reg_t bank_index(input arch_reg_t r, input mode_t m);
        phy_reg_t p;
        p = phy_reg_t'(r);
        if ((m == MODE_FIQ) && (r >= 8) && (r <= 14))
                p = 16 + r - 8;
        else if ((r == 13) || (r == 14))
        begin
                case (m)
                MODE_IRQ: p = 23 + r - 13;
                MODE_SVC: p = 25 + r - 13;
                MODE_ABT: p = 27 + r - 13;
                MODE_UND: p = 29 + r - 13;
                default:  p = phy_reg_t'(r);
                endcase
        end
        return p;
endfunction

function automatic word_t mcr_word(input logic [3:0] crn, input arch_reg_t rd);
        return {4'hE, 4'b1110, 3'b000, 1'b0, crn, rd, 4'hF, 3'b000, 1'b1, 4'h0};
endfunction

function automatic word_t mrc_word(input logic [3:0] crn, input arch_reg_t rd);
        return {4'hE, 4'b1110, 3'b000, 1'b1, crn, rd, 4'hF, 3'b000, 1'b1, 4'h0};
endfunction

function automatic word_t ldc_word(input arch_reg_t rn, input logic [3:0] crd);
        return {4'hE, 3'b110, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, rn, crd, 4'hF, 8'h04};
endfunction

function automatic word_t cdp_word(input logic [3:0] crn);
        return {4'hE, 4'b1110, 4'h0, crn, 4'h1, 4'hF, 3'b000, 1'b0, 4'h2};
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp)
        begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                error_count++;
        end
endtask

task automatic check_bus(input string name, input fetch_bus_t got, input fetch_bus_t exp);
        check_count++;
        if (got !== exp)
        begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                error_count++;
        end
endtask

task automatic check_req(input string name, input copro_req_t got, input copro_req_t exp);
        check_count++;
        if (got !== exp)
        begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                error_count++;
        end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                error_count++;
        end
endtask

task automatic drain_pipe();
        repeat (PIPE_DEPTH)
        begin
                @(posedge i_clk);
                i_fetch  <= '0;
                i_retire <= 1'b1;
        end
        @(posedge i_clk);
        i_retire <= 1'b0;
endtask

task automatic write_reg(input phy_reg_t addr, input word_t data);
        @(posedge i_clk);
        i_wb <= {1'b1, addr, data};
        @(posedge i_clk);
        i_wb <= '0;
endtask

task automatic read_reg(input phy_reg_t addr, output word_t data);
        @(posedge i_clk);
        i_rd_addr <= addr;
        @(negedge i_clk);
        data = o_rd_data;
endtask

task automatic present_instr(input word_t instr, input mode_t m);
        @(posedge i_clk);
        i_cpsr  <= {27'd0, m};
        i_fetch <= {1'b1, instr, 1'b0, 1'b0};
        @(negedge i_clk);
endtask

// Called at a falling edge.
task automatic await_request(input copro_req_t exp);
        int n;
        n = 0;
        while (!o_copro_req.dav && (n < WAIT_LIMIT))
        begin
                @(negedge i_clk);
                n++;
        end
        if (!o_copro_req.dav)
        begin
                $display("ERROR: no coprocessor request within %0d cycles", WAIT_LIMIT);
                error_count++;
        end
        else
        begin
                check_req("o_copro_req", o_copro_req, exp);
        end
endtask

task automatic complete_hand_off();
        int n;
        n = 0;
        while (o_stall_from_decode && (n < WAIT_LIMIT))
        begin
                @(negedge i_clk);
                n++;
        end
        if (o_stall_from_decode)
        begin
                $display("ERROR: decode stall not released within %0d cycles", WAIT_LIMIT);
                error_count++;
        end
        @(posedge i_clk);
        i_fetch <= '0;          // Fetch moves on.
        @(negedge i_clk);
        check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b0);
endtask

task automatic hand_off(input word_t instr, input mode_t m, input phy_reg_t preg);
        present_instr(instr, m);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b1);
        check_bit("o_decode.valid", o_decode.valid, 1'b0);
        await_request({1'b1, instr, preg});
        complete_hand_off();
endtask

task automatic passthrough_words();
        word_t      w;
        fetch_bus_t exp;
        logic       thumb;
        for (int i = 0; i < 24; i++)
        begin
                w = rand_word();
                thumb = (i % 4) == 3;
                if (thumb)
                        w = {w[31:28], 4'b1110, w[23:0]}; // Coprocessor form.
                else
                        w[27] = 1'b0;
                exp = {1'b1, w, lfsr_bit(), lfsr_bit()};
                @(posedge i_clk);
                i_cpsr  <= {26'd0, thumb, MODE_USR};
                i_fetch <= exp;
                @(negedge i_clk);
                check_bus("o_decode", o_decode, exp);
                check_bit("o_stall_from_decode", o_stall_from_decode, 1'b0);
        end
        drain_pipe();
endtask

task automatic drain_wait();
        word_t instr;
        instr = mcr_word(4'd2, 4'd14);
        for (int i = 0; i < 3; i++)
                present_instr({rand_word() & 32'hF7FF_FFFF}, MODE_USR);
        present_instr(instr, MODE_SVC);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b1);
        for (int i = 0; i < 3; i++)
        begin
                @(posedge i_clk);
                i_retire <= 1'b1;
                @(negedge i_clk);
                check_bit("o_stall_from_decode", o_stall_from_decode, 1'b1);
                check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        end
        @(posedge i_clk);
        i_retire <= 1'b0;
        @(negedge i_clk);
        check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        await_request({1'b1, instr, bank_index(4'd14, MODE_SVC)});
        complete_hand_off();
endtask

task automatic mcr_mrc_banking();
        word_t got;
        word_t irq_value;
        cr5_value = rand_word();
        write_reg(bank_index(4'd13, MODE_IRQ), cr5_value);
        write_reg(bank_index(4'd13, MODE_SVC), rand_word());
        hand_off(mcr_word(4'd5, 4'd13), MODE_IRQ, bank_index(4'd13, MODE_IRQ));
        irq_value = rand_word();
        write_reg(bank_index(4'd13, MODE_IRQ), irq_value); // IRQ R13 now differs from CR5.
        hand_off(mrc_word(4'd5, 4'd13), MODE_SVC, bank_index(4'd13, MODE_SVC));
        read_reg(6'd25, got);
        check_word("o_rd_data phy 25", got, cr5_value);
        read_reg(6'd23, got);
        check_word("o_rd_data phy 23", got, irq_value);
endtask

task automatic ldc_cdp_handoff();
        word_t abt_value;
        word_t r5_value;
        word_t got;
        abt_value = rand_word();
        r5_value  = rand_word();
        write_reg(bank_index(4'd13, MODE_ABT), abt_value);
        write_reg(6'd5, r5_value);
        hand_off(ldc_word(4'd13, 4'd5), MODE_ABT, bank_index(4'd13, MODE_ABT));
        hand_off(cdp_word(4'd5), MODE_FIQ, bank_index(4'd5, MODE_FIQ));
        read_reg(bank_index(4'd13, MODE_ABT), got);
        check_word("o_rd_data abt r13", got, abt_value);
        read_reg(6'd5, got);
        check_word("o_rd_data phy 5", got, r5_value);
        hand_off(mrc_word(4'd5, 4'd2), MODE_USR, bank_index(4'd2, MODE_USR));
        read_reg(6'd2, got);
        check_word("o_rd_data cr5 copy", got, cr5_value);
endtask

task automatic stall_in_busy();
        word_t later;
        word_t got;
        later = rand_word();
        write_reg(6'd0, rand_word());
        present_instr(mrc_word(4'd5, 4'd0), MODE_USR);
        await_request({1'b1, mrc_word(4'd5, 4'd0), bank_index(4'd0, MODE_USR)});
        @(posedge i_clk);
        i_stall_from_shifter <= 1'b1;
        i_rd_addr            <= 6'd0;
        repeat (6)
        begin
                @(negedge i_clk);
                check_bit("o_copro_req.dav", o_copro_req.dav, 1'b1);
                check_bit("o_stall_from_decode", o_stall_from_decode, 1'b1);
        end
        check_word("o_rd_data phy 0", o_rd_data, cr5_value);
        write_reg(6'd0, later); // A second MRC write would undo this.
        @(posedge i_clk);
        i_stall_from_shifter <= 1'b0;
        @(negedge i_clk);
        complete_hand_off();
        read_reg(6'd0, got);
        check_word("o_rd_data phy 0", got, later);
endtask

task automatic clear_and_restart(input logic from_writeback, input word_t next_instr);
        fetch_bus_t pass;
        pass = {1'b1, rand_word() & 32'hF7FF_FFFF, 1'b0, 1'b0};
        @(posedge i_clk);
        i_clear_from_writeback <= from_writeback;
        i_clear_from_alu       <= !from_writeback;
        i_fetch                <= '0;
        @(posedge i_clk);
        i_fetch <= pass;
        @(negedge i_clk);
        check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b0);
        check_bus("o_decode", o_decode, pass);
        @(posedge i_clk);
        i_clear_from_writeback <= 1'b0;
        i_clear_from_alu       <= 1'b0;
        i_cpsr                 <= {27'd0, MODE_USR};
        i_fetch                <= {1'b1, next_instr, 1'b0, 1'b0};
        @(negedge i_clk);
        // No retire follows, so the count must already be zero.
        await_request({1'b1, next_instr, bank_index(next_instr[15:12], MODE_USR)});
        complete_hand_off();
endtask

task automatic clear_mid_request();
        word_t got;
        present_instr(rand_word() & 32'hF7FF_FFFF, MODE_USR);
        present_instr(rand_word() & 32'hF7FF_FFFF, MODE_USR);
        present_instr(mcr_word(4'd7, 4'd1), MODE_USR);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b1);
        check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        clear_and_restart(1'b0, mcr_word(4'd3, 4'd1));
        present_instr(cdp_word(4'd4), MODE_USR);
        await_request({1'b1, cdp_word(4'd4), bank_index(4'd4, MODE_USR)});
        clear_and_restart(1'b1, mrc_word(4'd5, 4'd3));
        read_reg(6'd3, got);
        check_word("o_rd_data phy 3", got, cr5_value);
endtask

initial
begin
        i_reset                <= 1'b1;
        i_fetch                <= '0;
        i_cpsr                 <= {27'd0, MODE_USR};
        i_clear_from_writeback <= 1'b0;
        i_clear_from_alu       <= 1'b0;
        i_stall_from_shifter   <= 1'b0;
        i_stall_from_issue     <= 1'b0;
        i_retire               <= 1'b0;
        i_wb                   <= '0;
        i_rd_addr              <= '0;
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_bit("o_copro_req.dav", o_copro_req.dav, 1'b0);
        check_bit("o_stall_from_decode", o_stall_from_decode, 1'b0);

        passthrough_words();
        drain_wait();
        mcr_mrc_banking();
        ldc_cdp_handoff();
        stall_in_busy();
        clear_mid_request();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
                $display("All tests passed!");
        else
                $display("Test failures found");
        $finish;
end

endmodule

/* files.f */
hw/cpu_pkg.sv
hw/reg_translate.sv
hw/predecode_coproc.sv
hw/pipe_occupancy.sv
hw/coproc_unit.sv
hw/phy_regfile.sv
hw/coproc_top.sv
tb/tb_coproc_top.sv
